//--- Bender.yml
package:
  name: cfg_space

sources:
  - verilog/cfg_pkg.sv
  - verilog/cfg_req_decode.sv
  - verilog/cfg_header_regs.sv
  - verilog/cfg_bar_decode.sv
  - verilog/cfg_resp_pipe.sv
  - verilog/cfg_space_top.sv
  - target: test
    files:
      - test/tb_cfg_space.sv

//--- project.f
verilog/cfg_pkg.sv
verilog/cfg_req_decode.sv
verilog/cfg_header_regs.sv
verilog/cfg_bar_decode.sv
verilog/cfg_resp_pipe.sv
verilog/cfg_space_top.sv
test/tb_cfg_space.sv

//--- test/tb_cfg_space.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cfg_space;

  localparam int CLK_PERIOD     = 4;    // ns
  localparam int RST_CYCLES     = 5;
  localparam int ACK_DELAY      = 3;    // edges from sample to ack
  localparam int TIMEOUT_MARGIN = 20;   // cycles on top of the table length
  localparam logic [31:0] SEED  = 32'h08e3_3ea4;

  // DUT identity and window setup
  localparam logic [7:0]  CFG_BUS          = 8'h12;
  localparam logic [4:0]  CFG_DEVICE       = 5'd3;
  localparam logic [2:0]  CFG_FUNC         = 3'd1;
  localparam logic [15:0] VENDOR_ID        = 16'hA5C3;
  localparam logic [15:0] DEVICE_ID        = 16'h7E21;
  localparam logic [15:0] SUBSYS_VENDOR_ID = 16'h3C96;
  localparam logic [15:0] SUBSYS_ID        = 16'h0B14;
  localparam logic [7:0]  CLASS_CODE       = 8'h03;
  localparam logic [7:0]  SUBCLASS         = 8'h80;
  localparam logic [7:0]  PROGIF           = 8'h01;
  localparam logic [7:0]  REVISION_ID      = 8'h2C;
  localparam logic [7:0]  CACHE_LINE       = 8'd8;
  localparam logic [31:0] ROM_ADDR         = 32'hFFFF_FFF0;
  localparam logic [31:0] BAR0_MASK        = 32'hFFFF_0000;
  localparam logic [31:0] BAR1_MASK        = 32'hFFFF_F000;
  localparam logic [31:0] BAR2_MASK        = 32'hFF00_0000;
  localparam logic [31:0] BAR0_RESET       = 32'h4000_0000;
  localparam logic [31:0] BAR1_RESET       = 32'h5000_0000;
  localparam logic [31:0] BAR2_RESET       = 32'h6000_0000;

  // one table row is applied for one cycle
  typedef struct packed {
    logic                  cs;
    logic                  cyc;
    logic                  we;
    cfg_pkg::cfg_cti_e     cti;
    logic [2:0]            func;      // function number put in padr
    cfg_pkg::cfg_word_e    word;
    logic [3:0]            sel;
    logic [31:0]           dat;
    logic [7:0]            tid;
    logic [31:0]           probe;     // raw padr when nonzero
    logic                  exp_ack;
    logic                  dat_care;  // read data checked on the ack
    logic [31:0]           exp_dat;
    cfg_pkg::cfg_bar_sel_t exp_sel;
  } stim_row_t;

  logic                  clk_i;
  logic                  rst_i;
  logic                  cs_i;
  cfg_pkg::cfg_req_t     req_i;
  cfg_pkg::cfg_resp_t    resp_o;
  cfg_pkg::cfg_bar_sel_t bar_sel_o;

  stim_row_t             row_q[$];
  cfg_pkg::cfg_resp_t    resp_q[$];   // scoreboard with the oldest first
  bit                    care_q[$];
  time                   due_q[$];    // negedge at which each ack is due
  cfg_pkg::cfg_bar_sel_t cur_sel;     // selects expected for the live row
  cfg_pkg::cfg_resp_t    exp_resp;
  bit                    exp_care;
  time                   exp_due;
  int                    cycle_cnt = 0;
  int                    cycle_limit = 0;

  cfg_space_top #(
    .CFG_BUS(CFG_BUS), .CFG_DEVICE(CFG_DEVICE), .CFG_FUNC(CFG_FUNC),
    .VENDOR_ID(VENDOR_ID), .DEVICE_ID(DEVICE_ID),
    .SUBSYS_VENDOR_ID(SUBSYS_VENDOR_ID), .SUBSYS_ID(SUBSYS_ID),
    .CLASS_CODE(CLASS_CODE), .SUBCLASS(SUBCLASS), .PROGIF(PROGIF),
    .REVISION_ID(REVISION_ID), .CACHE_LINE(CACHE_LINE), .ROM_ADDR(ROM_ADDR),
    .BAR0_RESET(BAR0_RESET), .BAR1_RESET(BAR1_RESET), .BAR2_RESET(BAR2_RESET),
    .BAR0_MASK(BAR0_MASK), .BAR1_MASK(BAR1_MASK), .BAR2_MASK(BAR2_MASK)
  ) u_dut (
    .clk_i(clk_i), .rst_i(rst_i), .cs_i(cs_i), .req_i(req_i),
    .resp_o(resp_o), .bar_sel_o(bar_sel_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ====================================================================
  // error reporting and compare tasks
  // ====================================================================

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_resp(input cfg_pkg::cfg_resp_t got, input cfg_pkg::cfg_resp_t exp,
                            input bit care);
    if (got.ack !== exp.ack || got.tid !== exp.tid || got.adr !== exp.adr ||
        (care && got.dat !== exp.dat)) begin
      stop_on_error($sformatf({"Fail @%0t: resp dat=%h tid=%h adr=%h, ",
                               "expected dat=%h tid=%h adr=%h"},
                              $time, got.dat, got.tid, got.adr, exp.dat, exp.tid, exp.adr));
    end
  endtask

  task automatic check_bar_sel(input cfg_pkg::cfg_bar_sel_t got,
                               input cfg_pkg::cfg_bar_sel_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Fail @%0t: bar_sel (bar2..bar0) %b, expected %b",
                              $time, got, exp));
    end
  endtask

  // ====================================================================
  // table construction
  // ====================================================================

  // type-0 address with bus in 27:20, device 19:15, func 14:12 and dword 11:2
  function automatic logic [31:0] cfg_addr(input logic [2:0] func,
                                           input cfg_pkg::cfg_word_e word);
    return {4'h0, CFG_BUS, CFG_DEVICE, func, word, 2'b00};
  endfunction

  task automatic push_row(input logic cs, input logic cyc, input logic we,
                          input cfg_pkg::cfg_cti_e cti, input logic [2:0] func,
                          input cfg_pkg::cfg_word_e word, input logic [3:0] sel,
                          input logic [31:0] dat, input logic [31:0] probe,
                          input logic exp_ack, input logic dat_care,
                          input logic [31:0] exp_dat, input cfg_pkg::cfg_bar_sel_t exp_sel);
    stim_row_t row;
    row.cs       = cs;
    row.cyc      = cyc;
    row.we       = we;
    row.cti      = cti;
    row.func     = func;
    row.word     = word;
    row.sel      = sel;
    row.dat      = dat;
    row.tid      = 8'($urandom());  // random tag per row
    row.probe    = probe;
    row.exp_ack  = exp_ack;
    row.dat_care = dat_care;
    row.exp_dat  = exp_dat;
    row.exp_sel  = exp_sel;
    row_q.push_back(row);
  endtask

  task automatic read_word(input cfg_pkg::cfg_word_e word, input logic [31:0] exp_dat);
    push_row(1'b1, 1'b1, 1'b0, cfg_pkg::CTI_CLASSIC, CFG_FUNC, word, 4'hF, $urandom(),
             32'h0, 1'b1, 1'b1, exp_dat, '0);
  endtask

  // only ERC writes come back with an ack
  task automatic write_word(input cfg_pkg::cfg_word_e word, input logic [3:0] sel,
                            input logic [31:0] dat, input cfg_pkg::cfg_cti_e cti);
    push_row(1'b1, 1'b1, 1'b1, cti, CFG_FUNC, word, sel, dat, 32'h0,
             cti == cfg_pkg::CTI_ERC, 1'b0, 32'h0, '0);
  endtask

  // plain bus cycle with cs low that only exercises the window selects
  task automatic probe_addr(input logic [31:0] adr, input cfg_pkg::cfg_bar_sel_t exp_sel);
    push_row(1'b0, 1'b1, 1'b0, cfg_pkg::CTI_CLASSIC, CFG_FUNC, cfg_pkg::W_ID, 4'hF,
             $urandom(), adr, 1'b0, 1'b0, 32'h0, exp_sel);
  endtask

  task automatic build_table();
    // identity words and reset state
    read_word(cfg_pkg::W_ID,       {DEVICE_ID, VENDOR_ID});
    read_word(cfg_pkg::W_CMD_STAT, 32'h02A0_0203);
    read_word(cfg_pkg::W_CLASS,    {CLASS_CODE, SUBCLASS, PROGIF, REVISION_ID});
    read_word(cfg_pkg::W_MISC,     {8'h00, 8'h00, 8'h00, CACHE_LINE});  // header type 0
    read_word(cfg_pkg::W_SUBSYS,   {SUBSYS_ID, SUBSYS_VENDOR_ID});
    read_word(cfg_pkg::W_ROM,      ROM_ADDR);
    read_word(cfg_pkg::W_BAR4,     32'hFFFF_FFFF);                      // absent BAR
    read_word(cfg_pkg::cfg_word_e'(10'd20), 32'h0000_0000);             // unmapped
    read_word(cfg_pkg::W_BAR0, BAR0_RESET);
    read_word(cfg_pkg::W_BAR1, BAR1_RESET);
    read_word(cfg_pkg::W_BAR2, BAR2_RESET);
    // command readback forces bit 9 high and bits 3,4,5,7,15:11 low
    write_word(cfg_pkg::W_CMD_STAT, 4'b0011, 32'h0000_FFFF, cfg_pkg::CTI_ERC);
    read_word(cfg_pkg::W_CMD_STAT, 32'h02A0_0747);
    write_word(cfg_pkg::W_CMD_STAT, 4'b0001, 32'h1234_5605, cfg_pkg::CTI_ERC);
    read_word(cfg_pkg::W_CMD_STAT, 32'h02A0_0705);                      // high byte kept
    // size probing
    write_word(cfg_pkg::W_BAR0, 4'hF, 32'hFFFF_FFFF, cfg_pkg::CTI_ERC);
    write_word(cfg_pkg::W_BAR1, 4'hF, 32'hFFFF_FFFF, cfg_pkg::CTI_ERC);
    write_word(cfg_pkg::W_BAR2, 4'hF, 32'hFFFF_FFFF, cfg_pkg::CTI_ERC);
    read_word(cfg_pkg::W_BAR0, BAR0_MASK);
    read_word(cfg_pkg::W_BAR1, BAR1_MASK);
    read_word(cfg_pkg::W_BAR2, BAR2_MASK);
    write_word(cfg_pkg::W_BAR1, 4'b1100, 32'h7000_ABCD, cfg_pkg::CTI_ERC);
    read_word(cfg_pkg::W_BAR1, {16'h7000, BAR1_MASK[15:0]});            // upper half only
    // all ones on two lanes is a plain byte write
    write_word(cfg_pkg::W_BAR0, 4'b0011, 32'hFFFF_FFFF, cfg_pkg::CTI_ERC);
    read_word(cfg_pkg::W_BAR0, {BAR0_MASK[31:16], 16'hFFFF});
    // window decode with select bits ordered {bar2, bar1, bar0}
    write_word(cfg_pkg::W_BAR0, 4'hF, 32'h4000_0000, cfg_pkg::CTI_ERC);
    probe_addr(32'h4000_1234, cfg_pkg::cfg_bar_sel_t'(3'b001));
    probe_addr(32'h7000_F8A0, cfg_pkg::cfg_bar_sel_t'(3'b010));
    probe_addr(32'h2345_6789, cfg_pkg::cfg_bar_sel_t'(3'b000));         // outside all
    probe_addr(32'hFF12_3456, cfg_pkg::cfg_bar_sel_t'(3'b100));
    // requests that must not be claimed
    push_row(1'b1, 1'b1, 1'b0, cfg_pkg::CTI_CLASSIC, 3'd2, cfg_pkg::W_ID, 4'hF,
             $urandom(), 32'h0, 1'b0, 1'b0, 32'h0, '0);                 // wrong function
    push_row(1'b1, 1'b1, 1'b1, cfg_pkg::CTI_ERC, 3'd2, cfg_pkg::W_BAR2, 4'hF,
             32'h1111_1111, 32'h0, 1'b0, 1'b0, 32'h0, '0);
    push_row(1'b0, 1'b1, 1'b1, cfg_pkg::CTI_ERC, CFG_FUNC, cfg_pkg::W_BAR2, 4'hF,
             32'h2222_2222, 32'h0, 1'b0, 1'b0, 32'h0, '0);              // cs low
    push_row(1'b0, 1'b1, 1'b0, cfg_pkg::CTI_CLASSIC, CFG_FUNC, cfg_pkg::W_ID, 4'hF,
             $urandom(), 32'h0, 1'b0, 1'b0, 32'h0, '0);
    read_word(cfg_pkg::W_BAR2, BAR2_MASK);                              // untouched
    // posted write takes effect without an ack
    write_word(cfg_pkg::W_BAR2, 4'hF, 32'h6000_0000, cfg_pkg::CTI_CLASSIC);
    read_word(cfg_pkg::W_BAR2, 32'h6000_0000);
    push_row(1'b0, 1'b0, 1'b0, cfg_pkg::CTI_CLASSIC, CFG_FUNC, cfg_pkg::W_ID, 4'h0,
             $urandom(), 32'h4000_5678, 1'b0, 1'b0, 32'h0, '0);         // idle in bar0 window
    // three back to back reads keep three in flight
    read_word(cfg_pkg::W_ID, {DEVICE_ID, VENDOR_ID});
    read_word(cfg_pkg::W_ROM, ROM_ADDR);
    read_word(cfg_pkg::W_BAR0, 32'h4000_0000);
  endtask

  // ====================================================================
  // stimulus
  // ====================================================================

  task automatic drive_row(input stim_row_t row);
    cfg_pkg::cfg_req_t  r;
    cfg_pkg::cfg_resp_t e;
    r.cyc  = row.cyc;
    r.we   = row.we;
    r.cti  = row.cti;
    r.sel  = row.sel;
    r.padr = (row.probe != 32'h0) ? row.probe : cfg_addr(row.func, row.word);
    r.dat  = row.dat;
    r.tid  = row.tid;
    cs_i  <= row.cs;
    req_i <= r;
    cur_sel = row.exp_sel;
    if (row.exp_ack) begin
      e.ack = 1'b1;
      e.dat = row.exp_dat;
      e.tid = row.tid;
      e.adr = r.padr;
      resp_q.push_back(e);
      care_q.push_back(row.dat_care);
      // DUT samples one period from now and acks ACK_DELAY edges later at a negedge
      due_q.push_back($time + CLK_PERIOD * (1 + ACK_DELAY) + CLK_PERIOD / 2);
    end
  endtask

  initial begin
    clk_i   = 1'b0;
    rst_i   = 1'b1;
    cs_i    = 1'b0;
    req_i   = '0;
    cur_sel = '0;
    void'($urandom(SEED));
    build_table();
    cycle_limit = row_q.size() + TIMEOUT_MARGIN;
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;
    foreach (row_q[i]) begin
      @(posedge clk_i);
      drive_row(row_q[i]);
    end
    @(posedge clk_i);
    cs_i   <= 1'b0;
    req_i  <= '0;
    cur_sel = '0;
    while (resp_q.size() != 0) @(posedge clk_i);  // drain the pipeline
    repeat (ACK_DELAY + 1) @(posedge clk_i);      // room for a stray ack
    $display("TB PASSED");
    $finish;
  end

  // ====================================================================
  // response monitor and timeout
  // ====================================================================

  always @(negedge clk_i) begin
    if (!rst_i) begin
      check_bar_sel(bar_sel_o, cur_sel);
      if (resp_o.ack !== 1'b0) begin
        if (resp_q.size() == 0) begin
          stop_on_error($sformatf("acknowledge at %0t with no request outstanding", $time));
        end else begin
          exp_resp = resp_q.pop_front();
          exp_care = care_q.pop_front();
          exp_due  = due_q.pop_front();
          if ($time != exp_due) begin
            stop_on_error($sformatf("Fail @%0t: ack arrived, expected at %0t",
                                    $time, exp_due));
          end else begin
            check_resp(resp_o, exp_resp, exp_care);
          end
        end
      end else if (due_q.size() != 0 && $time >= due_q[0]) begin
        stop_on_error($sformatf("acknowledge due at %0t never came", due_q[0]));
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      stop_on_error($sformatf("timeout after %0d cycles, run did not finish", cycle_cnt));
    end
  end

endmodule

`default_nettype wire

//--- verilog/cfg_bar_decode.sv
`timescale 1ns/1ps
`default_nettype none

// address window selects for the three BARs
// decoded straight off the live request, no config claim needed

module cfg_bar_decode #(
  parameter logic [31:0] BAR0_MASK = 32'h0000_0000,
  parameter logic [31:0] BAR1_MASK = 32'h0000_0000,
  parameter logic [31:0] BAR2_MASK = 32'h0000_0000
) (
  input  var cfg_pkg::cfg_req_t  req_i,
  input  var logic [2:0][31:0]   bars_i,
  output cfg_pkg::cfg_bar_sel_t  bar_sel_o
);

  localparam logic [2:0][31:0] BAR_MASK = {BAR2_MASK, BAR1_MASK, BAR0_MASK};

  logic [2:0] hit;

  // a window matches when padr and the BAR agree on every mask bit
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      hit[i] = req_i.cyc && (((req_i.padr ^ bars_i[i]) & BAR_MASK[i]) == 32'h0);
    end
  end

  assign bar_sel_o.bar0 = hit[0];
  assign bar_sel_o.bar1 = hit[1];
  assign bar_sel_o.bar2 = hit[2];

endmodule

`default_nettype wire

//--- verilog/cfg_header_regs.sv
`timescale 1ns/1ps
`default_nettype none

// type-0 header storage: command register, three BARs with size
// probing, and the registered read mux for the whole header

module cfg_header_regs #(
  parameter logic [15:0] VENDOR_ID        = 16'h0000,
  parameter logic [15:0] DEVICE_ID        = 16'h0000,
  parameter logic [15:0] SUBSYS_VENDOR_ID = 16'h0000,
  parameter logic [15:0] SUBSYS_ID        = 16'h0000,
  parameter logic [7:0]  CLASS_CODE       = 8'h03,
  parameter logic [7:0]  SUBCLASS         = 8'h80,
  parameter logic [7:0]  PROGIF           = 8'h01,
  parameter logic [7:0]  REVISION_ID      = 8'h00,
  parameter logic [7:0]  CACHE_LINE       = 8'd8,
  parameter logic [31:0] ROM_ADDR         = 32'hFFFF_FFF0,
  parameter logic [31:0] BAR0_RESET       = 32'h0000_0001,
  parameter logic [31:0] BAR1_RESET       = 32'h0000_0001,
  parameter logic [31:0] BAR2_RESET       = 32'h0000_0001,
  parameter logic [31:0] BAR0_MASK        = 32'h0000_0000,
  parameter logic [31:0] BAR1_MASK        = 32'h0000_0000,
  parameter logic [31:0] BAR2_MASK        = 32'h0000_0000
) (
  input  var logic               clk_i,
  input  var logic               rst_i,
  input  var logic               rd_i,     // claimed read this cycle
  input  var logic               wr_i,     // claimed write this cycle
  input  var cfg_pkg::cfg_word_e word_i,
  input  var cfg_pkg::cfg_req_t  req_i,
  output logic [31:0]            rdata_o,
  output logic [2:0][31:0]       bars_o
);

  // per-BAR constants, indexed the same way as bars_o
  localparam logic [2:0][31:0] BAR_RESET = {BAR2_RESET, BAR1_RESET, BAR0_RESET};
  localparam logic [2:0][31:0] BAR_MASK  = {BAR2_MASK, BAR1_MASK, BAR0_MASK};

  logic [15:0] cmd_q;        // raw command bits as written
  logic [15:0] cmd_rd;       // command as seen on readback
  logic        cmd_wr;
  logic [2:0]  bar_wr;       // write hits BARn
  logic        size_probe;   // all-ones word on all lanes

  // ====================================================================
  // write decode
  // ====================================================================

  assign cmd_wr    = wr_i && (word_i == cfg_pkg::W_CMD_STAT);
  assign bar_wr[0] = wr_i && (word_i == cfg_pkg::W_BAR0);
  assign bar_wr[1] = wr_i && (word_i == cfg_pkg::W_BAR1);
  assign bar_wr[2] = wr_i && (word_i == cfg_pkg::W_BAR2);

  assign size_probe = (&req_i.sel) && (&req_i.dat);

  // ====================================================================
  // command and BAR storage
  // ====================================================================

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cmd_q  <= cfg_pkg::CMD_RESET;
      bars_o <= BAR_RESET;
    end else begin
      // command is the low half of word 1, status half is read-only
      if (cmd_wr) begin
        if (req_i.sel[0]) cmd_q[7:0]  <= req_i.dat[7:0];
        if (req_i.sel[1]) cmd_q[15:8] <= req_i.dat[15:8];
      end

      for (int i = 0; i < 3; i++) begin
        if (bar_wr[i]) begin
          if (size_probe) begin
            bars_o[i] <= BAR_MASK[i];  // software reads back the size
          end else begin
            for (int b = 0; b < 4; b++) begin
              if (req_i.sel[b]) bars_o[i][8*b +: 8] <= req_i.dat[8*b +: 8];
            end
          end
        end
      end
    end
  end

  // fixed fields override whatever was stored
  assign cmd_rd = (cmd_q & ~cfg_pkg::CMD_FORCE_ZERO) | cfg_pkg::CMD_FORCE_ONE;

  // ====================================================================
  // read mux, one cycle of latency
  // ====================================================================

  always_ff @(posedge clk_i) begin
    if (rd_i) begin
      case (word_i)
        cfg_pkg::W_ID:       rdata_o <= {DEVICE_ID, VENDOR_ID};
        cfg_pkg::W_CMD_STAT: rdata_o <= {cfg_pkg::STAT_CONST, cmd_rd};
        cfg_pkg::W_CLASS:    rdata_o <= {CLASS_CODE, SUBCLASS, PROGIF, REVISION_ID};
        cfg_pkg::W_MISC: begin
          // bist and latency timer not implemented
          rdata_o <= {8'h00, cfg_pkg::HEADER_TYPE, 8'h00, CACHE_LINE};
        end
        cfg_pkg::W_BAR0:     rdata_o <= bars_o[0];
        cfg_pkg::W_BAR1:     rdata_o <= bars_o[1];
        cfg_pkg::W_BAR2:     rdata_o <= bars_o[2];
        cfg_pkg::W_BAR3,
        cfg_pkg::W_BAR4,
        cfg_pkg::W_BAR5:     rdata_o <= 32'hFFFF_FFFF;  // absent BARs
        cfg_pkg::W_SUBSYS:   rdata_o <= {SUBSYS_ID, SUBSYS_VENDOR_ID};
        cfg_pkg::W_ROM:      rdata_o <= ROM_ADDR;
        default:             rdata_o <= 32'h0000_0000;  // cis, cap, unmapped
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/cfg_pkg.sv
`default_nettype none

// ======================================================================
// shared types and constants for the configuration-space target
// ======================================================================

package cfg_pkg;

  // bus cycle-type code, carried with every request
  typedef enum logic [2:0] {
    CTI_CLASSIC = 3'd0,  // single transfer
    CTI_FIXED   = 3'd1,  // constant address burst
    CTI_INCR    = 3'd2,  // incrementing burst
    CTI_ERC     = 3'd7   // write wants an acknowledge
  } cfg_cti_e;

  // request as seen on the bus, one cycle per transaction
  typedef struct packed {
    logic        cyc;   // cycle valid
    logic        we;    // write enable
    cfg_cti_e    cti;   // cycle type
    logic [3:0]  sel;   // byte lanes
    logic [31:0] padr;  // physical address
    logic [31:0] dat;   // write data
    logic [7:0]  tid;   // transaction id
  } cfg_req_t;

  // response returned after the fixed latency
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;   // read data, don't care on a write ack
    logic [7:0]  tid;   // echoed from the request
    logic [31:0] adr;   // echoed padr
  } cfg_resp_t;

  // window selects, one per implemented BAR
  typedef struct packed {
    logic bar2;
    logic bar1;
    logic bar0;
  } cfg_bar_sel_t;

  // type-0 header word index, padr[11:2]
  typedef enum logic [9:0] {
    W_ID       = 10'd0,   // device id / vendor id
    W_CMD_STAT = 10'd1,   // status / command
    W_CLASS    = 10'd2,   // class, subclass, prog-if, revision
    W_MISC     = 10'd3,   // bist, header type, latency, cache line
    W_BAR0     = 10'd4,
    W_BAR1     = 10'd5,
    W_BAR2     = 10'd6,
    W_BAR3     = 10'd7,   // unimplemented, reads all ones
    W_BAR4     = 10'd8,
    W_BAR5     = 10'd9,
    W_CIS      = 10'd10,  // cardbus cis pointer
    W_SUBSYS   = 10'd11,  // subsystem id / subsystem vendor id
    W_ROM      = 10'd12,  // expansion rom base
    W_CAP      = 10'd13   // capabilities pointer
  } cfg_word_e;

  // ====================================================================
  // register layout
  // ====================================================================

  localparam logic [15:0] CMD_RESET      = 16'h4003;  // io + mem space on
  // bit 9: fast back-to-back enable is hardwired
  localparam logic [15:0] CMD_FORCE_ONE  = 16'h0200;
  // special cycles, mwi, palette snoop, bit 7 and 15:11 reserved
  localparam logic [15:0] CMD_FORCE_ZERO = 16'hF8B8;

  // 66 MHz capable, fast b2b capable, medium devsel timing
  localparam logic [15:0] STAT_CONST     = 16'h02A0;

  localparam logic [7:0]  HEADER_TYPE    = 8'h00;     // general device

  localparam int          RESP_LATENCY   = 3;         // cycles to ack

endpackage

`default_nettype wire

//--- verilog/cfg_req_decode.sv
`timescale 1ns/1ps
`default_nettype none

// claims config requests aimed at this bus/device/function and
// splits them into read, write and acked write strobes

module cfg_req_decode #(
  parameter logic [7:0] CFG_BUS    = 8'h00,
  parameter logic [4:0] CFG_DEVICE = 5'h00,
  parameter logic [2:0] CFG_FUNC   = 3'h0
) (
  input  var logic              cs_i,
  input  var cfg_pkg::cfg_req_t req_i,
  output logic                  rd_o,
  output logic                  wr_o,
  output logic                  ack_wr_o,
  output cfg_pkg::cfg_word_e    word_o
);

  logic bdf_match;  // bus/device/function fields agree
  logic claim;

  // type-0 style address: bus 27:20, device 19:15, func 14:12
  assign bdf_match = (req_i.padr[27:20] == CFG_BUS)    &&
                     (req_i.padr[19:15] == CFG_DEVICE) &&
                     (req_i.padr[14:12] == CFG_FUNC);

  assign claim = cs_i && req_i.cyc && bdf_match;

  assign rd_o = claim && !req_i.we;
  assign wr_o = claim &&  req_i.we;

  // only ERC writes get a response, others are posted silently
  assign ack_wr_o = wr_o && (req_i.cti == cfg_pkg::CTI_ERC);

  // dword index within the 4 KB function space
  assign word_o = cfg_pkg::cfg_word_e'(req_i.padr[11:2]);

endmodule

`default_nettype wire

//--- verilog/cfg_resp_pipe.sv
`timescale 1ns/1ps
`default_nettype none

// fixed-latency response path
// stage 0 takes the launch with tid/adr, read data joins at stage 1
// once the header mux has registered it, the output register is the ack

module cfg_resp_pipe (
  input  var logic               clk_i,
  input  var logic               rst_i,
  input  var logic               launch_i,  // read or acked write claimed
  input  var logic [31:0]        rdata_i,   // valid one cycle after launch
  input  var logic [7:0]         tid_i,
  input  var logic [31:0]        adr_i,
  output cfg_pkg::cfg_resp_t     resp_o
);

  localparam int LAT = cfg_pkg::RESP_LATENCY;

  logic [LAT-1:0]        vld_q;
  logic [LAT-1:0][7:0]   tid_q;
  logic [LAT-1:0][31:0]  adr_q;
  logic [LAT-1:1][31:0]  dat_q;   // no stage 0, data arrives late
  logic                  ack_q;
  logic [7:0]            tid_o_q;
  logic [31:0]           adr_o_q;
  logic [31:0]           dat_o_q;

  // valid bits, the only reset state in here
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      vld_q <= '0;
      ack_q <= 1'b0;
    end else begin
      vld_q <= {vld_q[LAT-2:0], launch_i};
      ack_q <= vld_q[LAT-1];  // one-cycle pulse per launch
    end
  end

  // payload shift
  always_ff @(posedge clk_i) begin
    tid_q[0] <= tid_i;
    adr_q[0] <= adr_i;
    dat_q[1] <= rdata_i;        // lines up with the register read
    for (int s = 1; s < LAT; s++) begin
      tid_q[s] <= tid_q[s-1];
      adr_q[s] <= adr_q[s-1];
    end
    for (int s = 2; s < LAT; s++) begin
      dat_q[s] <= dat_q[s-1];
    end
    tid_o_q <= tid_q[LAT-1];
    adr_o_q <= adr_q[LAT-1];
    dat_o_q <= dat_q[LAT-1];
  end

  assign resp_o.ack = ack_q;
  assign resp_o.dat = dat_o_q;
  assign resp_o.tid = tid_o_q;
  assign resp_o.adr = adr_o_q;

endmodule

`default_nettype wire

//--- verilog/cfg_space_top.sv
`timescale 1ns/1ps
`default_nettype none

// configuration-space target, type-0 header on a 32-bit split bus

module cfg_space_top #(
  parameter logic [7:0]  CFG_BUS          = 8'h00,
  parameter logic [4:0]  CFG_DEVICE       = 5'h00,
  parameter logic [2:0]  CFG_FUNC         = 3'h0,
  parameter logic [15:0] VENDOR_ID        = 16'h0000,
  parameter logic [15:0] DEVICE_ID        = 16'h0000,
  parameter logic [15:0] SUBSYS_VENDOR_ID = 16'h0000,
  parameter logic [15:0] SUBSYS_ID        = 16'h0000,
  parameter logic [7:0]  CLASS_CODE       = 8'h03,   // display controller
  parameter logic [7:0]  SUBCLASS         = 8'h80,   // other
  parameter logic [7:0]  PROGIF           = 8'h01,
  parameter logic [7:0]  REVISION_ID      = 8'h00,
  parameter logic [7:0]  CACHE_LINE       = 8'd8,    // in 32-bit units
  parameter logic [31:0] ROM_ADDR         = 32'hFFFF_FFF0,
  parameter logic [31:0] BAR0_RESET       = 32'h0000_0001,
  parameter logic [31:0] BAR1_RESET       = 32'h0000_0001,
  parameter logic [31:0] BAR2_RESET       = 32'h0000_0001,
  parameter logic [31:0] BAR0_MASK        = 32'h0000_0000,
  parameter logic [31:0] BAR1_MASK        = 32'h0000_0000,
  parameter logic [31:0] BAR2_MASK        = 32'h0000_0000
) (
  input  var logic                  clk_i,
  input  var logic                  rst_i,
  input  var logic                  cs_i,
  input  var cfg_pkg::cfg_req_t     req_i,
  output cfg_pkg::cfg_resp_t        resp_o,
  output cfg_pkg::cfg_bar_sel_t     bar_sel_o
);

  logic               rd;
  logic               wr;
  logic               ack_wr;
  logic               launch;   // anything that will be acked
  cfg_pkg::cfg_word_e word;
  logic [31:0]        rdata;
  logic [2:0][31:0]   bars;

  assign launch = rd || ack_wr;

  cfg_req_decode #(
    .CFG_BUS(CFG_BUS), .CFG_DEVICE(CFG_DEVICE), .CFG_FUNC(CFG_FUNC)
  ) u_decode (
    .cs_i(cs_i), .req_i(req_i), .rd_o(rd), .wr_o(wr), .ack_wr_o(ack_wr), .word_o(word)
  );

  cfg_header_regs #(
    .VENDOR_ID(VENDOR_ID), .DEVICE_ID(DEVICE_ID),
    .SUBSYS_VENDOR_ID(SUBSYS_VENDOR_ID), .SUBSYS_ID(SUBSYS_ID),
    .CLASS_CODE(CLASS_CODE), .SUBCLASS(SUBCLASS), .PROGIF(PROGIF),
    .REVISION_ID(REVISION_ID), .CACHE_LINE(CACHE_LINE), .ROM_ADDR(ROM_ADDR),
    .BAR0_RESET(BAR0_RESET), .BAR1_RESET(BAR1_RESET), .BAR2_RESET(BAR2_RESET),
    .BAR0_MASK(BAR0_MASK), .BAR1_MASK(BAR1_MASK), .BAR2_MASK(BAR2_MASK)
  ) u_regs (
    .clk_i(clk_i), .rst_i(rst_i), .rd_i(rd), .wr_i(wr), .word_i(word),
    .req_i(req_i), .rdata_o(rdata), .bars_o(bars)
  );

  cfg_bar_decode #(
    .BAR0_MASK(BAR0_MASK), .BAR1_MASK(BAR1_MASK), .BAR2_MASK(BAR2_MASK)
  ) u_bars (
    .req_i(req_i), .bars_i(bars), .bar_sel_o(bar_sel_o)
  );

  cfg_resp_pipe u_resp (
    .clk_i(clk_i), .rst_i(rst_i), .launch_i(launch), .rdata_i(rdata),
    .tid_i(req_i.tid), .adr_i(req_i.padr), .resp_o(resp_o)
  );

endmodule

`default_nettype wire
